// File: core.f
src/rv_pkg.sv
src/instr_fetch.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu_exec.sv
src/writeback_stage.sv
src/core.sv
tests/core_checker.sv
tests/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= ./$(BUILD_DIR)/V$(TOP)
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output.
run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

   localparam int reset_cycles = 10;
   localparam int n_retire     = 140;

   logic            clk = 1'b0;
   logic            arst_n, run, imem_we;
   logic [31:0]     imem_addr, imem_wdata;
   logic            retire_valid;
   rv_pkg::retire_t retire;

   logic [31:0] prog [0:255];
   logic [31:0] model_regs [0:31];
   logic [31:0] model_pc = '0;
   logic [15:0] lfsr = 16'd48631;
   int          prog_len = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int          last_retire = -1;
   int          retired = 0;
   int          errors = 0;
   logic        started = 1'b0;
   logic        timed_out = 1'b0;

   always #4 clk = ~clk;

   core #(.imem_words(256)) u_dut (
      .clk(clk), .arst_n(arst_n), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
      .imem_wdata(imem_wdata), .retire_valid(retire_valid), .retire(retire)
   );

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit handed out.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   // RV32I integer rules for the supported funct3 codes; returns 0 for anything else.
   function automatic bit alu_ref(input logic [2:0] f3, input logic sub, input logic [31:0] a,
                                  input logic [31:0] b, output logic [31:0] y);
      y       = '0;
      alu_ref = 1'b1;
      case (f3)
         3'b000:  y = sub ? a - b : a + b;
         3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b100:  y = a ^ b;
         3'b110:  y = a | b;
         3'b111:  y = a & b;
         default: alu_ref = 1'b0;
      endcase
   endfunction

   task automatic add_word(input logic [31:0] w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
   endtask

   task automatic build_program();
      logic [4:0] rd, rs1, rs2;
      logic [2:0] pick, f3;
      logic [1:0] kind;
      int         n;
      for (n = 0; n < 120; n++) begin
         kind = 2'(take_bits(2)); // Half register-register, a quarter each I-type and LUI.
         rd   = 5'(take_bits(3));
         rs1  = 5'(take_bits(3));
         rs2  = 5'(take_bits(3));
         pick = 3'(take_bits(3));
         case (pick)
            3'd2:       f3 = 3'b111;
            3'd3:       f3 = 3'b110;
            3'd4:       f3 = 3'b100;
            3'd5, 3'd6: f3 = 3'b010;
            default:    f3 = 3'b000;
         endcase
         if (kind == 2'd3) begin
            add_word(u_type(20'(take_bits(20)), rd));
         end else if (kind == 2'd2) begin
            add_word(i_type(12'(take_bits(12)), rs1, f3, rd));
         end else begin
            add_word(r_type((pick == 3'd1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
         end
      end
      add_word(i_type(12'd5, 5'd0, 3'b000, 5'd8));
      add_word(i_type(12'd5, 5'd0, 3'b000, 5'd9));
      add_word(i_type(12'hFFD, 5'd0, 3'b000, 5'd10));    // x10 = -3.
      add_word(i_type(12'd7, 5'd8, 3'b000, 5'd0));       // Aimed at x0.
      add_word(r_type(7'h00, 5'd8, 5'd10, 3'b010, 5'd14)); // Signed compare gives 1.
      add_word(i_type(12'hFFF, 5'd8, 3'b010, 5'd15));
      add_word(b_type(13'd8, 5'd9, 5'd8, 3'b000));       // BEQ taken.
      add_word(i_type(12'd1, 5'd0, 3'b000, 5'd11));
      add_word(b_type(13'd8, 5'd10, 5'd8, 3'b000));      // BEQ not taken.
      add_word(b_type(13'd8, 5'd10, 5'd8, 3'b001));      // BNE taken.
      add_word(i_type(12'd2, 5'd0, 3'b000, 5'd11));
      add_word(b_type(13'd8, 5'd9, 5'd8, 3'b001));       // BNE not taken.
      add_word(j_type(21'd8, 5'd12));
      add_word(i_type(12'd3, 5'd0, 3'b000, 5'd11));
      add_word(i_type(12'd1, 5'd8, 3'b001, 5'd13));      // SLLI, unsupported.
      add_word(b_type(13'd8, 5'd9, 5'd8, 3'b100));       // BLT, unsupported.
      add_word(32'hFFFF_FFFF);
      add_word(j_type(21'd0, 5'd0));                     // Parks the core on itself.
   endtask

   // Samples at the rising edge, where the DUT outputs still show the closing cycle.
   always @(posedge clk) begin : monitor
      logic [31:0] ins, a, b, y, next_pc;
      logic [4:0]  rd;
      logic        ok, exp_wr;
      cycle_count++;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         timed_out = 1'b1;
      end
      if (!started) begin
         assert (retire_valid !== 1'b1) else begin
            $display("Error at %0d ns: an instruction retired before run was raised", $time);
            errors++;
         end
      end
      if (run) begin
         started = 1'b1;
      end
      if (retire_valid) begin
         if (last_retire >= 0) begin
            assert (cycle_count - last_retire == 4)
               else report_mismatch("retire interval", 32'd4, cycle_count - last_retire);
         end
         last_retire = cycle_count;
         ins     = prog[model_pc[9:2]];
         rd      = ins[11:7];
         a       = model_regs[ins[19:15]];
         b       = model_regs[ins[24:20]];
         y       = '0;
         ok      = 1'b0;
         next_pc = model_pc + 32'd4;
         case (ins[6:0])
            7'b0110011: begin
               if (ins[31:25] == 7'h00) begin
                  ok = alu_ref(ins[14:12], 1'b0, a, b, y);
               end else if (ins[31:25] == 7'h20 && ins[14:12] == 3'b000) begin
                  ok = alu_ref(3'b000, 1'b1, a, b, y);
               end
            end
            7'b0010011: ok = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]}, y);
            7'b0110111: begin
               ok = 1'b1;
               y  = {ins[31:12], 12'b0};
            end
            7'b1100011: begin
               if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                  next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
               end
            end
            7'b1101111: begin
               ok      = 1'b1;
               y       = model_pc + 32'd4;
               next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                     ins[30:21], 1'b0};
            end
            default: ok = 1'b0;
         endcase
         exp_wr = ok && (rd != 5'd0); // x0 is never written.
         assert (retire.pc == model_pc) else report_mismatch("retire.pc", model_pc, retire.pc);
         assert (retire.rd == rd) else report_mismatch("retire.rd", 32'(rd), 32'(retire.rd));
         assert (retire.wr_en == exp_wr)
            else report_mismatch("retire.wr_en", 32'(exp_wr), 32'(retire.wr_en));
         if (exp_wr) begin
            assert (retire.value == y) else report_mismatch("retire.value", y, retire.value);
            model_regs[rd] = y;
         end
         model_pc = next_pc;
         retired++;
      end
   end

   initial begin
      int i;
      arst_n     = 1'b0;
      run        = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      for (i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      build_program();
      cycle_limit = (reset_cycles + prog_len + 4 * n_retire) * 2;
      repeat (reset_cycles) @(posedge clk);
      #1 arst_n = 1'b1;
      for (i = 0; i < prog_len; i++) begin
         @(posedge clk);
         #1;
         imem_we    = 1'b1;
         imem_addr  = i;
         imem_wdata = prog[i];
      end
      // This write arrives together with run and has to be dropped.
      @(posedge clk);
      #1;
      run        = 1'b1;
      imem_addr  = 32'd60;
      imem_wdata = 32'h7ff00093; // ADDI x1, x0, 2047.
      @(posedge clk);
      #1;
      imem_we = 1'b0;
      while (retired < n_retire && !timed_out) begin
         @(negedge clk);
      end
      if (timed_out) begin
         $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
                  retired, n_retire, cycle_limit);
      end
      $display("Summary: %0d model mismatches, %0d assertion failures, %0d retirements",
               errors, u_dut.u_checker.fail_count, retired);
      if (errors == 0 && u_dut.u_checker.fail_count == 0 && !timed_out) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker (
   input wire logic       clk,
   input wire logic       arst_n,
   input wire logic       run,
   input wire logic [1:0] phase,
   input wire logic       retire_valid,
   input wire logic       wr_en,
   input wire logic [4:0] wr_addr
);

   int fail_count = 0; // Number of failed assertions so far.

   // Every phase except an idle FETCH moves on by exactly one step per cycle.
   phase_step: assert property (@(posedge clk) disable iff (!arst_n)
      (phase != rv_pkg::FETCH || run) |=> (phase == $past(phase) + 2'd1))
      else begin
         $error("Sequencer phase did not advance by one step");
         fail_count++;
      end

   // At least three quiet cycles lie between two retirements.
   retire_spacing: assert property (@(posedge clk) disable iff (!arst_n)
      retire_valid |-> !$past(retire_valid, 1) && !$past(retire_valid, 2) &&
                       !$past(retire_valid, 3))
      else begin
         $error("Two retirements came closer than four cycles apart");
         fail_count++;
      end

   no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> wr_addr != 5'd0)
      else begin
         $error("Register write was aimed at x0");
         fail_count++;
      end

endmodule

bind core core_checker u_checker (
   .clk(clk), .arst_n(arst_n), .run(run), .phase(phase),
   .retire_valid(retire_valid), .wr_en(wr_en), .wr_addr(wr_addr)
);

`default_nettype wire

// File: src/core.sv
`timescale 1ns/1ps
`default_nettype none

module core #(
   parameter int imem_words = 256
) (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    run,
   input  wire logic                    imem_we,
   input  wire logic [rv_pkg::xlen-1:0] imem_addr,
   input  wire logic [rv_pkg::xlen-1:0] imem_wdata,
   output logic                         retire_valid,
   output rv_pkg::retire_t              retire
);

   rv_pkg::phase_t          phase;
   logic [rv_pkg::xlen-1:0] pc;
   logic [rv_pkg::xlen-1:0] next_pc;
   logic [rv_pkg::xlen-1:0] instr_raw;
   rv_pkg::decoded_instr_t  decoded;
   rv_pkg::exec_result_t    result;
   logic [rv_pkg::xlen-1:0] rs1_value, rs2_value;
   logic                    wr_en;
   logic [4:0]              wr_addr;
   logic [rv_pkg::xlen-1:0] wr_data;
   logic                    load_en, fetch_en, decode_en, exec_en, write_phase;

   assign load_en     = imem_we && !run; // Program loading only while stopped.
   assign fetch_en    = (phase == rv_pkg::FETCH) && run;
   assign decode_en   = (phase == rv_pkg::DECODE);
   assign exec_en     = (phase == rv_pkg::EXEC);
   assign write_phase = (phase == rv_pkg::WRITE);

   // A started instruction always runs to the end; only FETCH waits for run.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase <= rv_pkg::FETCH;
         pc    <= '0;
      end else begin
         case (phase)
            rv_pkg::FETCH:  if (run) phase <= rv_pkg::DECODE;
            rv_pkg::DECODE: phase <= rv_pkg::EXEC;
            rv_pkg::EXEC:   phase <= rv_pkg::WRITE;
            rv_pkg::WRITE: begin
               phase <= rv_pkg::FETCH;
               pc    <= next_pc;
            end
            default: phase <= rv_pkg::FETCH;
         endcase
      end
   end

   instr_fetch #(.imem_words(imem_words)) u_fetch (
      .clk(clk), .arst_n(arst_n),
      .load_en(load_en), .load_addr(imem_addr), .load_data(imem_wdata),
      .pc(pc), .fetch_en(fetch_en), .instr_raw(instr_raw)
   );

   instr_decoder u_decoder (
      .clk(clk), .arst_n(arst_n), .decode_en(decode_en),
      .instr_raw(instr_raw), .pc(pc), .decoded(decoded)
   );

   reg_file u_regs (
      .clk(clk), .arst_n(arst_n),
      .rs1_addr(decoded.rs1), .rs2_addr(decoded.rs2),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .rs1_value(rs1_value), .rs2_value(rs2_value)
   );

   alu_exec u_exec (
      .clk(clk), .arst_n(arst_n), .exec_en(exec_en), .decoded(decoded),
      .rs1_value(rs1_value), .rs2_value(rs2_value), .result(result)
   );

   writeback_stage u_wb (
      .write_phase(write_phase), .result(result), .pc(pc),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .retire_valid(retire_valid), .retire(retire), .next_pc(next_pc)
   );

endmodule

`default_nettype wire

// File: src/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
   input  wire logic                    write_phase,
   input  wire rv_pkg::exec_result_t    result,
   input  wire logic [rv_pkg::xlen-1:0] pc,
   output logic                         wr_en,
   output logic      [4:0]              wr_addr,
   output logic      [rv_pkg::xlen-1:0] wr_data,
   output logic                         retire_valid,
   output rv_pkg::retire_t              retire,
   output logic      [rv_pkg::xlen-1:0] next_pc
);

   // The result register holds still through WRITE, so everything here is combinational.
   assign wr_en   = write_phase && result.wr_en;
   assign wr_addr = result.rd;
   assign wr_data = result.value;

   assign retire_valid = write_phase; // One pulse per instruction.

   always_comb begin
      retire.pc    = pc;
      retire.rd    = result.rd;
      retire.value = result.value;
      retire.wr_en = result.wr_en;
   end

   // Taken branches and JAL redirect, everything else falls through.
   assign next_pc = result.jump ? result.target : pc + 32'd4;

endmodule

`default_nettype wire

// File: src/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    exec_en,
   input  wire rv_pkg::decoded_instr_t  decoded,
   input  wire logic [rv_pkg::xlen-1:0] rs1_value,
   input  wire logic [rv_pkg::xlen-1:0] rs2_value,
   output rv_pkg::exec_result_t         result
);

   logic [rv_pkg::xlen-1:0] op_b;
   logic [rv_pkg::xlen-1:0] value;
   logic                    less;
   logic                    jump;

   assign op_b = decoded.uses_imm ? decoded.imm : rs2_value;
   assign less = $signed(rs1_value) < $signed(op_b); // SLT and SLTI compare signed.

   always_comb begin
      value = '0;
      jump  = 1'b0;
      case (decoded.op)
         rv_pkg::ADD: value = rs1_value + op_b;
         rv_pkg::SUB: value = rs1_value - op_b;
         rv_pkg::AND: value = rs1_value & op_b;
         rv_pkg::OR:  value = rs1_value | op_b;
         rv_pkg::XOR: value = rs1_value ^ op_b;
         rv_pkg::SLT: value = {{(rv_pkg::xlen-1){1'b0}}, less};
         rv_pkg::LUI: value = decoded.imm;
         rv_pkg::BEQ: jump  = (rs1_value == rs2_value);
         rv_pkg::BNE: jump  = (rs1_value != rs2_value);
         rv_pkg::JAL: begin
            value = decoded.pc + 32'd4; // Link address.
            jump  = 1'b1;
         end
         default: value = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else if (exec_en) begin
         result.wr_en  <= decoded.writes_rd;
         result.rd     <= decoded.rd;
         result.value  <= value;
         result.jump   <= jump;
         result.target <= decoded.pc + decoded.imm; // Shared by branches and JAL.
      end
   end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic [4:0]              rs1_addr,
   input  wire logic [4:0]              rs2_addr,
   input  wire logic                    wr_en,
   input  wire logic [4:0]              wr_addr,
   input  wire logic [rv_pkg::xlen-1:0] wr_data,
   output logic      [rv_pkg::xlen-1:0] rs1_value,
   output logic      [rv_pkg::xlen-1:0] rs2_value
);

   logic [rv_pkg::xlen-1:0] regs [1:31]; // x0 has no storage.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_addr != 5'd0) begin
         regs[wr_addr] <= wr_data;
      end
   end

   assign rs1_value = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
   assign rs2_value = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    decode_en,
   input  wire logic [rv_pkg::xlen-1:0] instr_raw,
   input  wire logic [rv_pkg::xlen-1:0] pc,
   output rv_pkg::decoded_instr_t       decoded
);

   logic [6:0]              opcode;
   logic [2:0]              funct3;
   logic [6:0]              funct7;
   logic [rv_pkg::xlen-1:0] imm_i, imm_u, imm_b, imm_j;
   rv_pkg::alu_op_t         op;
   logic [rv_pkg::xlen-1:0] imm;
   logic                    uses_imm;

   assign opcode = instr_raw[6:0];
   assign funct3 = instr_raw[14:12];
   assign funct7 = instr_raw[31:25];

   assign imm_i = {{20{instr_raw[31]}}, instr_raw[31:20]};
   assign imm_u = {instr_raw[31:12], 12'b0};
   assign imm_b = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7],
                   instr_raw[30:25], instr_raw[11:8], 1'b0};
   assign imm_j = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12],
                   instr_raw[20], instr_raw[30:21], 1'b0};

   always_comb begin
      op       = rv_pkg::NOP; // Anything not matched below retires as a no-op.
      imm      = '0;
      uses_imm = 1'b0;
      case (opcode)
         7'b0110011: begin // Register-register group.
            if (funct7 == 7'b0000000) begin
               case (funct3)
                  3'b000:  op = rv_pkg::ADD;
                  3'b010:  op = rv_pkg::SLT;
                  3'b100:  op = rv_pkg::XOR;
                  3'b110:  op = rv_pkg::OR;
                  3'b111:  op = rv_pkg::AND;
                  default: op = rv_pkg::NOP;
               endcase
            end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
               op = rv_pkg::SUB;
            end
         end
         7'b0010011: begin
            imm      = imm_i;
            uses_imm = 1'b1;
            case (funct3)
               3'b000:  op = rv_pkg::ADD;
               3'b010:  op = rv_pkg::SLT;
               3'b100:  op = rv_pkg::XOR;
               3'b110:  op = rv_pkg::OR;
               3'b111:  op = rv_pkg::AND;
               default: op = rv_pkg::NOP; // Shifts and SLTIU are not supported.
            endcase
         end
         7'b0110111: begin
            op       = rv_pkg::LUI;
            imm      = imm_u;
            uses_imm = 1'b1;
         end
         7'b1100011: begin
            imm = imm_b; // Branch offset. The comparison uses rs2.
            if (funct3 == 3'b000) begin
               op = rv_pkg::BEQ;
            end else if (funct3 == 3'b001) begin
               op = rv_pkg::BNE;
            end
         end
         7'b1101111: begin
            op  = rv_pkg::JAL;
            imm = imm_j;
         end
         default: op = rv_pkg::NOP;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         decoded <= '0;
      end else if (decode_en) begin
         decoded.op        <= op;
         decoded.rd        <= instr_raw[11:7];
         decoded.rs1       <= instr_raw[19:15];
         decoded.rs2       <= instr_raw[24:20];
         decoded.imm       <= imm;
         decoded.pc        <= pc;
         decoded.uses_imm  <= uses_imm;
         decoded.writes_rd <= (op != rv_pkg::NOP) && (op != rv_pkg::BEQ) &&
                              (op != rv_pkg::BNE) && (instr_raw[11:7] != 5'd0);
      end
   end

endmodule

`default_nettype wire

// File: src/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
   parameter int imem_words = 256
) (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    load_en,
   input  wire logic [rv_pkg::xlen-1:0] load_addr,
   input  wire logic [rv_pkg::xlen-1:0] load_data,
   input  wire logic [rv_pkg::xlen-1:0] pc,
   input  wire logic                    fetch_en,
   output logic      [rv_pkg::xlen-1:0] instr_raw
);

   localparam int aw = $clog2(imem_words);

   logic [rv_pkg::xlen-1:0] mem [imem_words];
   logic [aw-1:0]           rd_index;
   logic [aw-1:0]           wr_index;

   // Both addresses wrap modulo the memory depth.
   assign rd_index = pc[aw+1:2];       // Byte address to word index.
   assign wr_index = load_addr[aw-1:0]; // The load port is already word addressed.

   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[wr_index] <= load_data;
      end
   end

   // The fetched word stays put until the next FETCH phase.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         instr_raw <= '0;
      end else if (fetch_en) begin
         instr_raw <= mem[rd_index];
      end
   end

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

   localparam int xlen = 32;

   // One clock cycle is spent in each phase.
   typedef enum logic [1:0] {
      FETCH  = 2'd0,
      DECODE = 2'd1,
      EXEC   = 2'd2,
      WRITE  = 2'd3
   } phase_t;

   typedef enum logic [3:0] {
      ADD = 4'd0,
      SUB = 4'd1,
      AND = 4'd2,
      OR  = 4'd3,
      XOR = 4'd4,
      SLT = 4'd5,
      LUI = 4'd6,
      BEQ = 4'd7,
      BNE = 4'd8,
      JAL = 4'd9,
      NOP = 4'd10
   } alu_op_t;

   typedef struct packed {
      alu_op_t          op;
      logic [4:0]       rd;
      logic [4:0]       rs1;
      logic [4:0]       rs2;
      logic [xlen-1:0]  imm;       // Already sign-extended.
      logic [xlen-1:0]  pc;
      logic             uses_imm;
      logic             writes_rd;
   } decoded_instr_t;

   typedef struct packed {
      logic             wr_en;
      logic [4:0]       rd;
      logic [xlen-1:0]  value;
      logic             jump;
      logic [xlen-1:0]  target;
   } exec_result_t;

   typedef struct packed {
      logic [xlen-1:0]  pc;
      logic [4:0]       rd;
      logic [xlen-1:0]  value;
      logic             wr_en;
   } retire_t;

endpackage

`default_nettype wire
